//--- files.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/store_agen.sv
rtl/store_buffer.sv
rtl/load_unit.sv
rtl/data_mem.sv
rtl/lsu_top.sv
sim/tb_lsu.sv

//--- Makefile
# Verilator build, run, lint and clean for the load/store unit

SRCS := files.f $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/Vtb_lsu: $(SRCS)
	verilator --binary --timing --assert -f files.f --top-module tb_lsu -o Vtb_lsu

run: obj_dir/Vtb_lsu
	./obj_dir/Vtb_lsu | tee sim.log
	grep -q "Test OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module lsu_top

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module tb_lsu;

    localparam int STIM_CYCLES = 2000;
    localparam int CYCLE_LIMIT = 3 * STIM_CYCLES;

    logic             clk_i, reset_i, mispredict_i;
    logic             st_alloc_i, st_exec_i, commit_i, ld_v_i;
    lsu_pkg::word_t   st_base_i, st_offset_i, st_data_i, ld_base_i, ld_offset_i;
    lsu_pkg::sb_idx_t st_sb_num_i, ld_sb_num_i;
    lsu_pkg::sb_idx_t st_alloc_num_o, st_retire_num_o, sb_commit_pt_o;
    logic             st_alloc_ready_o, st_retire_o, ld_valid_o, ld_fwd_o;
    lsu_pkg::word_t   ld_data_o;
    lsu_pkg::sb_vec_t sb_wb_vec_o;

    // reference model state
    logic             m_wb   [`LSU_SB_ENTRY];
    logic             m_exec [`LSU_SB_ENTRY];
    lsu_pkg::word_t   m_addr [`LSU_SB_ENTRY];
    lsu_pkg::word_t   m_data [`LSU_SB_ENTRY];
    lsu_pkg::word_t   m_mem  [`LSU_MEM_WORDS];
    lsu_pkg::sb_idx_t m_alloc_pt, m_commit_pt;
    int               m_free;
    // store in the address stage and the load waiting for its result
    logic             ag_v, pl_v, pl_fwd;
    lsu_pkg::sb_idx_t ag_idx;
    lsu_pkg::word_t   ag_addr, ag_data, pl_data;

    int err_cnt = 0;
    int chk_cnt = 0;
    int cycle_cnt = 0;

    lsu_top i_lsu_top (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .mispredict_i     (mispredict_i),
        .st_alloc_i       (st_alloc_i),
        .st_alloc_num_o   (st_alloc_num_o),
        .st_alloc_ready_o (st_alloc_ready_o),
        .st_exec_i        (st_exec_i),
        .st_base_i        (st_base_i),
        .st_offset_i      (st_offset_i),
        .st_data_i        (st_data_i),
        .st_sb_num_i      (st_sb_num_i),
        .commit_i         (commit_i),
        .st_retire_o      (st_retire_o),
        .st_retire_num_o  (st_retire_num_o),
        .ld_v_i           (ld_v_i),
        .ld_base_i        (ld_base_i),
        .ld_offset_i      (ld_offset_i),
        .ld_sb_num_i      (ld_sb_num_i),
        .ld_valid_o       (ld_valid_o),
        .ld_data_o        (ld_data_o),
        .ld_fwd_o         (ld_fwd_o),
        .sb_wb_vec_o      (sb_wb_vec_o),
        .sb_commit_pt_o   (sb_commit_pt_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the stimulus did not finish", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input lsu_pkg::word_t exp_val,
                               input lsu_pkg::word_t act_val);
        chk_cnt++;
        if (exp_val !== act_val)
        begin
            err_cnt++;
            $display("[FAIL] %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    // one of 8 words so stores and loads collide often
    function automatic lsu_pkg::word_t pick_addr();
        return 32'h40 + ($urandom_range(0, 7) << 2);
    endfunction

    task automatic drive_idle();
        mispredict_i = 1'b0;
        st_alloc_i   = 1'b0;
        st_exec_i    = 1'b0;
        commit_i     = 1'b0;
        ld_v_i       = 1'b0;
        st_base_i    = '0;
        st_offset_i  = '0;
        st_data_i    = '0;
        st_sb_num_i  = '0;
        ld_base_i    = '0;
        ld_offset_i  = '0;
        ld_sb_num_i  = '0;
    endtask

    task automatic clear_model();
        for (int i = 0; i < `LSU_SB_ENTRY; i++)
        begin
            m_wb[i]   = 1'b0;
            m_exec[i] = 1'b0;
        end
        m_alloc_pt  = '0;
        m_commit_pt = '0;
        m_free      = `LSU_SB_ENTRY;
        ag_v        = 1'b0;
        pl_v        = 1'b0;
    endtask

    task automatic drive_random();
        int               occ;
        lsu_pkg::sb_idx_t cand [$];
        lsu_pkg::sb_idx_t idx;
        lsu_pkg::word_t   addr;
        occ = `LSU_SB_ENTRY - m_free;
        mispredict_i = ($urandom_range(0, 99) < 2);
        st_alloc_i   = !mispredict_i && (m_free != 0) && ($urandom_range(0, 1) == 1);
        // allocated stores that have not executed yet
        for (int r = 0; r < occ; r++)
        begin
            idx = m_commit_pt + lsu_pkg::sb_idx_t'(r);
            if (!m_exec[idx])
                cand.push_back(idx);
        end
        st_exec_i   = (cand.size() != 0) && ($urandom_range(0, 9) < 6);
        st_sb_num_i = (cand.size() != 0) ? cand[$urandom_range(0, cand.size() - 1)] : '0;
        addr        = pick_addr();
        st_base_i   = $urandom_range(0, 15) << 2;
        st_offset_i = addr - st_base_i;
        st_data_i   = $urandom();
        commit_i    = !mispredict_i && (occ != 0) && ($urandom_range(0, 1) == 1);
        ld_v_i      = ($urandom_range(0, 9) < 6);
        addr        = pick_addr();
        ld_base_i   = $urandom_range(0, 15) << 2;
        ld_offset_i = addr - ld_base_i;
        ld_sb_num_i = m_commit_pt
                    + lsu_pkg::sb_idx_t'((occ != 0) ? $urandom_range(0, occ - 1) : 0);
    endtask

    // check the outputs mid-cycle and advance the model over the next edge
    task automatic step_cycle();
        logic             retire;
        logic             nxt_fwd;
        lsu_pkg::sb_vec_t wb_vec;
        lsu_pkg::word_t   ld_addr;
        lsu_pkg::word_t   nxt_data;
        lsu_pkg::sb_idx_t idx;
        int               rel;
        @(negedge clk_i);
        retire = commit_i && m_wb[m_commit_pt];
        for (int i = 0; i < `LSU_SB_ENTRY; i++)
            wb_vec[i] = m_wb[i];
        check_value("alloc_ready", (m_free != 0) && !mispredict_i, st_alloc_ready_o);
        check_value("alloc_num", m_alloc_pt, st_alloc_num_o);
        check_value("commit_pt", m_commit_pt, sb_commit_pt_o);
        check_value("wb_vec", wb_vec, sb_wb_vec_o);
        check_value("retire", retire, st_retire_o);
        if (retire)
            check_value("retire_num", m_commit_pt, st_retire_num_o);
        check_value("ld_valid", pl_v && !mispredict_i, ld_valid_o);
        if (pl_v && !mispredict_i)
        begin
            check_value("ld_data", pl_data, ld_data_o);
            check_value("ld_fwd", pl_fwd, ld_fwd_o);
        end

        // youngest matching written-back store from the head up to the load's store
        ld_addr  = ld_base_i + ld_offset_i;
        nxt_fwd  = 1'b0;
        nxt_data = m_mem[ld_addr[7:2]];
        rel      = int'(lsu_pkg::sb_idx_t'(ld_sb_num_i - m_commit_pt));
        for (int r = 0; r <= rel; r++)
        begin
            idx = m_commit_pt + lsu_pkg::sb_idx_t'(r);
            if (m_wb[idx] && (m_addr[idx] == ld_addr))
            begin
                nxt_fwd  = 1'b1;
                nxt_data = m_data[idx];
            end
        end
        pl_v    = ld_v_i && !mispredict_i;
        pl_fwd  = nxt_fwd;
        pl_data = nxt_data;

        if (retire)
            m_mem[m_addr[m_commit_pt][7:2]] = m_data[m_commit_pt];
        if (ag_v)
        begin
            m_wb[ag_idx]   = 1'b1;
            m_addr[ag_idx] = ag_addr;
            m_data[ag_idx] = ag_data;
        end
        if (st_alloc_i)
        begin
            m_wb[m_alloc_pt]   = 1'b0;
            m_exec[m_alloc_pt] = 1'b0;
            m_alloc_pt         = m_alloc_pt + 1'b1;
            m_free             = m_free - 1;
        end
        if (retire)
        begin
            m_wb[m_commit_pt] = 1'b0;
            m_commit_pt       = m_commit_pt + 1'b1;
            m_free            = m_free + 1;
        end
        ag_v    = st_exec_i && !mispredict_i;
        ag_idx  = st_sb_num_i;
        ag_addr = st_base_i + st_offset_i;
        ag_data = st_data_i;
        if (st_exec_i)
            m_exec[st_sb_num_i] = 1'b1;
        if (mispredict_i)
            clear_model();
        @(posedge clk_i);
        #2;
    endtask

    initial
    begin
        void'($urandom(32'h1efb_7ac9));
        drive_idle();
        // a load held during reset must not come out as valid
        ld_v_i  = 1'b1;
        reset_i = 1'b1;
        clear_model();
        for (int i = 0; i < `LSU_MEM_WORDS; i++)
            m_mem[i] = '0;
        repeat (4) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        ld_v_i  = 1'b0;
        // commit request on an empty buffer must not retire
        commit_i = 1'b1;

        @(negedge clk_i);
        check_value("reset alloc_ready", 1'b1, st_alloc_ready_o);
        check_value("reset retire", 1'b0, st_retire_o);
        check_value("reset ld_valid", 1'b0, ld_valid_o);
        check_value("reset commit_pt", '0, sb_commit_pt_o);
        @(posedge clk_i);
        #2;
        commit_i = 1'b0;

        // fill the buffer until ready drops
        repeat (`LSU_SB_ENTRY)
        begin
            st_alloc_i = 1'b1;
            step_cycle();
        end
        st_alloc_i = 1'b0;
        step_cycle();

        repeat (STIM_CYCLES)
        begin
            drive_random();
            step_cycle();
        end
        drive_idle();
        step_cycle();

        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- rtl/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_top
(
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             mispredict_i,
    // store allocation
    input  logic             st_alloc_i,
    output lsu_pkg::sb_idx_t st_alloc_num_o,
    output logic             st_alloc_ready_o,
    // store execute
    input  logic             st_exec_i,
    input  lsu_pkg::word_t   st_base_i,
    input  lsu_pkg::word_t   st_offset_i,
    input  lsu_pkg::word_t   st_data_i,
    input  lsu_pkg::sb_idx_t st_sb_num_i,
    // commit and retirement
    input  logic             commit_i,
    output logic             st_retire_o,
    output lsu_pkg::sb_idx_t st_retire_num_o,
    // load
    input  logic             ld_v_i,
    input  lsu_pkg::word_t   ld_base_i,
    input  lsu_pkg::word_t   ld_offset_i,
    input  lsu_pkg::sb_idx_t ld_sb_num_i,
    output logic             ld_valid_o,
    output lsu_pkg::word_t   ld_data_o,
    output logic             ld_fwd_o,
    // issue store check
    output lsu_pkg::sb_vec_t sb_wb_vec_o,
    output lsu_pkg::sb_idx_t sb_commit_pt_o
);

    logic              wb_v;
    lsu_pkg::sb_idx_t  wb_idx;
    lsu_pkg::word_t    wb_addr;
    lsu_pkg::word_t    wb_data;
    logic              mem_we;
    lsu_pkg::word_t    mem_addr;
    lsu_pkg::word_t    mem_wdata;
    lsu_pkg::word_t    fwd_addr;
    lsu_pkg::sb_idx_t  fwd_sb_num;
    logic              fwd_hit;
    lsu_pkg::word_t    fwd_data;
    lsu_pkg::mem_idx_t rd_addr;
    lsu_pkg::word_t    rd_data;

    store_agen i_store_agen (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .flush_i   (mispredict_i),
        .exec_i    (st_exec_i),
        .base_i    (st_base_i),
        .offset_i  (st_offset_i),
        .data_i    (st_data_i),
        .sb_num_i  (st_sb_num_i),
        .wb_v_o    (wb_v),
        .wb_idx_o  (wb_idx),
        .wb_addr_o (wb_addr),
        .wb_data_o (wb_data)
    );

    store_buffer i_store_buffer (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .flush_i       (mispredict_i),
        .alloc_i       (st_alloc_i),
        .alloc_num_o   (st_alloc_num_o),
        .alloc_ready_o (st_alloc_ready_o),
        .wb_v_i        (wb_v),
        .wb_idx_i      (wb_idx),
        .wb_addr_i     (wb_addr),
        .wb_data_i     (wb_data),
        .commit_i      (commit_i),
        .retire_o      (st_retire_o),
        .retire_num_o  (st_retire_num_o),
        .mem_we_o      (mem_we),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .fwd_addr_i    (fwd_addr),
        .fwd_sb_num_i  (fwd_sb_num),
        .fwd_hit_o     (fwd_hit),
        .fwd_data_o    (fwd_data),
        .wb_vec_o      (sb_wb_vec_o),
        .commit_pt_o   (sb_commit_pt_o)
    );

    load_unit i_load_unit (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (mispredict_i),
        .ld_v_i       (ld_v_i),
        .base_i       (ld_base_i),
        .offset_i     (ld_offset_i),
        .sb_num_i     (ld_sb_num_i),
        .fwd_addr_o   (fwd_addr),
        .fwd_sb_num_o (fwd_sb_num),
        .fwd_hit_i    (fwd_hit),
        .fwd_data_i   (fwd_data),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data),
        .ld_valid_o   (ld_valid_o),
        .ld_data_o    (ld_data_o),
        .ld_fwd_o     (ld_fwd_o)
    );

    data_mem i_data_mem (
        .clk_i   (clk_i),
        .we_i    (mem_we),
        .waddr_i (mem_addr),
        .wdata_i (mem_wdata),
        .raddr_i (rd_addr),
        .rdata_o (rd_data)
    );

endmodule

//--- rtl/data_mem.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module data_mem
(
    input  logic              clk_i,
    input  logic              we_i,
    input  lsu_pkg::word_t    waddr_i,
    input  lsu_pkg::word_t    wdata_i,
    input  lsu_pkg::mem_idx_t raddr_i,
    output lsu_pkg::word_t    rdata_o
);

    lsu_pkg::word_t    mem [`LSU_MEM_WORDS];
    lsu_pkg::mem_idx_t widx;

    // byte address to word index
    assign widx = waddr_i[$clog2(`LSU_MEM_WORDS)+1:2];

    // known contents at power-up
    initial
    begin
        for (int i = 0; i < `LSU_MEM_WORDS; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk_i)
    begin
        if (we_i)
            mem[widx] <= wdata_i;
    end

    assign rdata_o = mem[raddr_i];

    // upper address bits would alias silently otherwise
    a_waddr_range: assert property (@(posedge clk_i)
        we_i |-> (waddr_i < lsu_pkg::word_t'(`LSU_MEM_WORDS * 4)));

endmodule

//--- rtl/load_unit.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_unit
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              flush_i,
    input  logic              ld_v_i,
    input  lsu_pkg::word_t    base_i,
    input  lsu_pkg::word_t    offset_i,
    input  lsu_pkg::sb_idx_t  sb_num_i,
    // store buffer forwarding
    output lsu_pkg::word_t    fwd_addr_o,
    output lsu_pkg::sb_idx_t  fwd_sb_num_o,
    input  logic              fwd_hit_i,
    input  lsu_pkg::word_t    fwd_data_i,
    // data memory read
    output lsu_pkg::mem_idx_t rd_addr_o,
    input  lsu_pkg::word_t    rd_data_i,
    // result
    output logic              ld_valid_o,
    output lsu_pkg::word_t    ld_data_o,
    output logic              ld_fwd_o
);

    lsu_pkg::word_t ld_addr;
    lsu_pkg::word_t ld_data_d;
    logic           ld_valid_q;
    lsu_pkg::word_t ld_data_q;
    logic           ld_fwd_q;

    assign ld_addr = base_i + offset_i;

    // same address goes to both the buffer and memory
    assign fwd_addr_o   = ld_addr;
    assign fwd_sb_num_o = sb_num_i;
    assign rd_addr_o    = ld_addr[$clog2(`LSU_MEM_WORDS)+1:2];

    // an older store in the buffer beats memory
    assign ld_data_d = fwd_hit_i ? fwd_data_i : rd_data_i;

    always_ff @(posedge clk_i)
    begin
        if (reset_i || flush_i)
            ld_valid_q <= 1'b0;
        else
            ld_valid_q <= ld_v_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (ld_v_i)
        begin
            ld_data_q <= ld_data_d;
            ld_fwd_q  <= fwd_hit_i;
        end
    end

    // a load finishing in the mispredict cycle is squashed too
    assign ld_valid_o = ld_valid_q && !flush_i;
    assign ld_data_o  = ld_data_q;
    assign ld_fwd_o   = ld_fwd_q;

    a_ld_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        ld_v_i |-> (ld_addr[1:0] == 2'b00));

endmodule

//--- rtl/store_buffer.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module store_buffer
(
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             flush_i,
    // allocation from rename
    input  logic             alloc_i,
    output lsu_pkg::sb_idx_t alloc_num_o,
    output logic             alloc_ready_o,
    // write-back from the store address unit
    input  logic             wb_v_i,
    input  lsu_pkg::sb_idx_t wb_idx_i,
    input  lsu_pkg::word_t   wb_addr_i,
    input  lsu_pkg::word_t   wb_data_i,
    // commit from the reorder buffer
    input  logic             commit_i,
    output logic             retire_o,
    output lsu_pkg::sb_idx_t retire_num_o,
    // drain port to data memory
    output logic             mem_we_o,
    output lsu_pkg::word_t   mem_addr_o,
    output lsu_pkg::word_t   mem_wdata_o,
    // load forwarding
    input  lsu_pkg::word_t   fwd_addr_i,
    input  lsu_pkg::sb_idx_t fwd_sb_num_i,
    output logic             fwd_hit_o,
    output lsu_pkg::word_t   fwd_data_o,
    // status for the issue store check
    output lsu_pkg::sb_vec_t wb_vec_o,
    output lsu_pkg::sb_idx_t commit_pt_o
);

    // per-entry state
    lsu_pkg::sb_vec_t wb_q;
    lsu_pkg::sb_vec_t wb_n;
    lsu_pkg::word_t   addr_q [`LSU_SB_ENTRY];
    lsu_pkg::word_t   data_q [`LSU_SB_ENTRY];

    lsu_pkg::sb_idx_t alloc_pt_q;
    lsu_pkg::sb_idx_t alloc_pt_n;
    lsu_pkg::sb_idx_t commit_pt_q;
    lsu_pkg::sb_idx_t commit_pt_n;
    lsu_pkg::sb_cnt_t free_cnt_q;
    lsu_pkg::sb_cnt_t free_cnt_n;

    // forwarding
    lsu_pkg::sb_vec_t match_vec;
    lsu_pkg::sb_vec_t rot_vec;
    lsu_pkg::sb_idx_t rel_num;
    lsu_pkg::sb_idx_t sel_rel;
    lsu_pkg::sb_idx_t sel_idx;
    logic             hit;

    assign alloc_num_o   = alloc_pt_q;
    assign alloc_ready_o = (free_cnt_q != '0) && !flush_i;

    // head store drains once it has its address and data
    assign retire_o     = commit_i && wb_q[commit_pt_q];
    assign retire_num_o = commit_pt_q;
    assign mem_we_o     = retire_o;
    assign mem_addr_o   = addr_q[commit_pt_q];
    assign mem_wdata_o  = data_q[commit_pt_q];

    assign wb_vec_o    = wb_q;
    assign commit_pt_o = commit_pt_q;

    always_comb
    begin
        wb_n        = wb_q;
        alloc_pt_n  = alloc_pt_q;
        commit_pt_n = commit_pt_q;
        free_cnt_n  = free_cnt_q;

        if (alloc_i)
        begin
            wb_n[alloc_pt_q] = 1'b0;
            alloc_pt_n       = alloc_pt_q + lsu_pkg::sb_idx_t'(1);
            free_cnt_n       = free_cnt_n - lsu_pkg::sb_cnt_t'(1);
        end

        if (wb_v_i)
            wb_n[wb_idx_i] = 1'b1;

        if (retire_o)
        begin
            wb_n[commit_pt_q] = 1'b0;
            commit_pt_n       = commit_pt_q + lsu_pkg::sb_idx_t'(1);
            free_cnt_n        = free_cnt_n + lsu_pkg::sb_cnt_t'(1);
        end

        // mispredict wins over everything else this cycle
        if (flush_i)
        begin
            wb_n        = '0;
            alloc_pt_n  = '0;
            commit_pt_n = '0;
            free_cnt_n  = lsu_pkg::sb_cnt_t'(`LSU_SB_ENTRY);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            wb_q        <= '0;
            alloc_pt_q  <= '0;
            commit_pt_q <= '0;
            free_cnt_q  <= lsu_pkg::sb_cnt_t'(`LSU_SB_ENTRY);
        end
        else
        begin
            wb_q        <= wb_n;
            alloc_pt_q  <= alloc_pt_n;
            commit_pt_q <= commit_pt_n;
            free_cnt_q  <= free_cnt_n;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (wb_v_i)
        begin
            addr_q[wb_idx_i] <= wb_addr_i;
            data_q[wb_idx_i] <= wb_data_i;
        end
    end

    // written-back entries hitting the load address
    always_comb
    begin
        match_vec = '0;
        for (int i = 0; i < `LSU_SB_ENTRY; i++)
        begin
            if (wb_q[i] && (addr_q[i] == fwd_addr_i))
                match_vec[i] = 1'b1;
        end
    end

    // rotate so the oldest store sits at bit 0
    always_comb
    begin
        for (int i = 0; i < `LSU_SB_ENTRY; i++)
            rot_vec[i] = match_vec[lsu_pkg::sb_idx_t'(i) + commit_pt_q];
    end

    // load's youngest older store, relative to the head
    assign rel_num = fwd_sb_num_i - commit_pt_q;

    // last hit at or below rel_num is the youngest older match
    always_comb
    begin
        hit     = 1'b0;
        sel_rel = '0;
        for (int i = 0; i < `LSU_SB_ENTRY; i++)
        begin
            if (rot_vec[i] && (lsu_pkg::sb_idx_t'(i) <= rel_num))
            begin
                hit     = 1'b1;
                sel_rel = lsu_pkg::sb_idx_t'(i);
            end
        end
    end

    assign sel_idx    = sel_rel + commit_pt_q;
    assign fwd_hit_o  = hit;
    assign fwd_data_o = data_q[sel_idx];

    a_alloc_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_i |-> alloc_ready_o);

    // each allocated store writes back exactly once
    a_single_wb: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_v_i |-> !wb_q[wb_idx_i]);

    a_retire_head: assert property (@(posedge clk_i) disable iff (reset_i)
        retire_o |-> wb_q[commit_pt_q] && (free_cnt_q != lsu_pkg::sb_cnt_t'(`LSU_SB_ENTRY)));

endmodule

//--- rtl/store_agen.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module store_agen
(
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic             exec_i,
    input  lsu_pkg::word_t   base_i,
    input  lsu_pkg::word_t   offset_i,
    input  lsu_pkg::word_t   data_i,
    input  lsu_pkg::sb_idx_t sb_num_i,
    output logic             wb_v_o,
    output lsu_pkg::sb_idx_t wb_idx_o,
    output lsu_pkg::word_t   wb_addr_o,
    output lsu_pkg::word_t   wb_data_o
);

    logic             wb_v_q;
    lsu_pkg::sb_idx_t wb_idx_q;
    lsu_pkg::word_t   wb_addr_q;
    lsu_pkg::word_t   wb_data_q;
    lsu_pkg::word_t   addr_sum;

    // effective address of the executed store
    assign addr_sum = base_i + offset_i;

    // valid stage, a mispredict drops the store in flight
    always_ff @(posedge clk_i)
    begin
        if (reset_i || flush_i)
            wb_v_q <= 1'b0;
        else
            wb_v_q <= exec_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (exec_i)
        begin
            wb_idx_q  <= sb_num_i;
            wb_addr_q <= addr_sum;
            wb_data_q <= data_i;
        end
    end

    assign wb_v_o    = wb_v_q;
    assign wb_idx_o  = wb_idx_q;
    assign wb_addr_o = wb_addr_q;
    assign wb_data_o = wb_data_q;

    // memory is word only, a misaligned store address is a core bug
    a_wb_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_v_o |-> (wb_addr_o[1:0] == 2'b00));

endmodule

//--- rtl/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

    // addresses, offsets and data
    typedef logic [`LSU_WORD_SIZE-1:0] word_t;

    // store buffer entry number
    typedef logic [$clog2(`LSU_SB_ENTRY)-1:0] sb_idx_t;

    // free-entry count, needs to hold the full depth
    typedef logic [$clog2(`LSU_SB_ENTRY):0] sb_cnt_t;

    // one bit per store buffer entry
    typedef logic [`LSU_SB_ENTRY-1:0] sb_vec_t;

    // data memory word index
    typedef logic [$clog2(`LSU_MEM_WORDS)-1:0] mem_idx_t;

endpackage

//--- rtl/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// store buffer entries
// must stay a power of two, pointers wrap by overflow
`define LSU_SB_ENTRY 8

// data and address width
`define LSU_WORD_SIZE 32

// data memory depth in words
// word index is taken from address bits 7:2
`define LSU_MEM_WORDS 64

`endif
